// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = mulAccelTb
FILELIST  = compile.f
OBJDIR    = obj_dir
PASSMSG   = TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

# Static checks only
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run, pass only when the pass line shows up
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) \
		-o $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// ==== compile.f ====
src/mulPkg.sv
src/opBus.sv
src/delayLine.sv
src/pipeMultiplier.sv
src/resultMerge.sv
src/axilFront.sv
src/mulAccelTop.sv
tests/resultChecker.sv
tests/mulAccelTb.sv

// ==== src/axilFront.sv ====
`default_nettype none

module axilFront #(
  parameter int FifoDepth = 4,
  localparam int CountWidth = $clog2(FifoDepth) + 1
) (
  input  logic                         clk,
  input  logic                         rstN,
  // Write address and data, accepted together
  input  logic [mulPkg::AddrWidth-1:0] AWADDR,
  input  logic                         AWVALID,
  output logic                         AWREADY,
  input  logic [mulPkg::DataWidth-1:0] WDATA,
  input  logic                         WVALID,
  output logic                         WREADY,
  // Write response
  output logic [1:0]                   BRESP,
  output logic                         BVALID,
  input  logic                         BREADY,
  // Read address
  input  logic [mulPkg::AddrWidth-1:0] ARADDR,
  input  logic                         ARVALID,
  output logic                         ARREADY,
  // Read data
  output logic [mulPkg::DataWidth-1:0] RDATA,
  output logic [1:0]                   RRESP,
  output logic                         RVALID,
  input  logic                         RREADY,
  // Launch toward the datapaths
  opBus.source                         ops,
  // Merge block status
  input  logic                         launchReady,
  input  logic                         headValid,
  input  mulPkg::resultT               headWord,
  input  logic [CountWidth-1:0]        fifoCount,
  input  logic [CountWidth-1:0]        inFlight,
  output logic                         pop
);
  import mulPkg::*;

  // ----------------------------------------------------------
  // Write channel
  // ----------------------------------------------------------
  logic wrAccept;
  logic isLaunch;

  assign isLaunch = (AWADDR == LaunchAddr);
  // Both halves present, no response pending, credit left
  assign wrAccept = AWVALID && WVALID && !BVALID && launchReady;
  assign AWREADY  = wrAccept;
  assign WREADY   = wrAccept;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      BVALID     <= 1'b0;
      ops.launch <= 1'b0;
    end else begin
      // One-cycle pulse on the accept edge
      ops.launch <= wrAccept && isLaunch;
      if (wrAccept) begin
        BVALID <= 1'b1;
      end else if (BREADY) begin
        BVALID <= 1'b0;
      end
    end
  end

  // Response code and operand fields, no reset
  always_ff @(posedge clk) begin
    if (wrAccept) begin
      BRESP <= isLaunch ? RespOkay : RespSlvErr;
    end
    if (wrAccept && isLaunch) begin
      // Strobes ignored, the whole word is taken
      ops.opA <= WDATA[OpWidth-1:0];
      ops.opB <= WDATA[2*OpWidth-1:OpWidth];
      ops.tag <= WDATA[DataWidth-1:2*OpWidth];
    end
  end

  // ----------------------------------------------------------
  // Read channel
  // ----------------------------------------------------------
  logic                 rdAccept;
  logic [DataWidth-1:0] rdData;
  logic [1:0]           rdResp;

  assign rdAccept = ARVALID && !RVALID;
  assign ARREADY  = rdAccept;

  // Address decode
  always_comb begin
    rdData = '0;
    rdResp = RespSlvErr;
    case (ARADDR)
      PopAddr: begin
        // Empty FIFO answers with an error and zero
        if (headValid) begin
          rdData = DataWidth'(headWord);
          rdResp = RespOkay;
        end
      end
      StatusAddr: begin
        rdData = DataWidth'({4'(inFlight), 4'(fifoCount)});
        rdResp = RespOkay;
      end
      default: begin
        rdResp = RespSlvErr;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      RVALID <= 1'b0;
      pop    <= 1'b0;
    end else begin
      pop <= rdAccept && (ARADDR == PopAddr) && headValid;
      if (rdAccept) begin
        RVALID <= 1'b1;
      end else if (RREADY) begin
        RVALID <= 1'b0;
      end
    end
  end

  // Read payload captured at accept
  always_ff @(posedge clk) begin
    if (rdAccept) begin
      RDATA <= rdData;
      RRESP <= rdResp;
    end
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  // Stalled responses stay put until the master takes them
  bRespHeld: assert property (
    @(posedge clk) disable iff (!rstN)
    BVALID && !BREADY |=> BVALID && $stable(BRESP)
  );

  rRespHeld: assert property (
    @(posedge clk) disable iff (!rstN)
    RVALID && !RREADY |=> RVALID && $stable(RDATA) && $stable(RRESP)
  );

endmodule

`default_nettype wire

// ==== src/delayLine.sv ====
`default_nettype none

module delayLine #(
  parameter int NumStages = 1,
  parameter type payloadT = logic
) (
  input  logic    clk,
  // Only the assertion looks at reset
  input  logic    rstN,
  input  payloadT in,
  output payloadT out
);

  // ----------------------------------------------------------
  // Register chain
  // ----------------------------------------------------------
  // Tap 0 is the input itself, tap NumStages is the output
  payloadT taps [NumStages+1];

  assign taps[0] = in;

  // No reset, the consumer masks the taps after reset
  for (genvar i = 1; i <= NumStages; i++) begin : genStage
    always_ff @(posedge clk) begin
      taps[i] <= taps[i-1];
    end
  end

  assign out = taps[NumStages];

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  // Output repeats the input from NumStages edges back
  // Four-state compare, payload fields may still be unknown
  delayMatches: assert property (
    @(posedge clk) disable iff (!rstN)
    ##NumStages out === $past(in, NumStages)
  );

  // Zero stages would need a bypass which this chain lacks
  initial begin
    if (NumStages < 1) begin
      $error("delayLine needs at least one stage");
    end
  end

endmodule

`default_nettype wire

// ==== src/mulAccelTop.sv ====
`default_nettype none

module mulAccelTop #(
  parameter int NumStages = 3,
  parameter int FifoDepth = 4,
  localparam int CountWidth = $clog2(FifoDepth) + 1
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic [mulPkg::AddrWidth-1:0] AWADDR,
  input  logic                         AWVALID,
  output logic                         AWREADY,
  input  logic [mulPkg::DataWidth-1:0] WDATA,
  input  logic                         WVALID,
  output logic                         WREADY,
  output logic [1:0]                   BRESP,
  output logic                         BVALID,
  input  logic                         BREADY,
  input  logic [mulPkg::AddrWidth-1:0] ARADDR,
  input  logic                         ARVALID,
  output logic                         ARREADY,
  output logic [mulPkg::DataWidth-1:0] RDATA,
  output logic [1:0]                   RRESP,
  output logic                         RVALID,
  input  logic                         RREADY
);
  import mulPkg::*;

  opBus ops ();

  logic                  launchReady;
  logic                  headValid;
  resultT                headWord;
  logic [CountWidth-1:0] fifoCount;
  logic [CountWidth-1:0] inFlight;
  logic                  pop;
  logic [ProdWidth-1:0]  product;
  tagSlotT               slotIn;
  tagSlotT               slotOut;

  // ----------------------------------------------------------
  // Front end
  // ----------------------------------------------------------
  axilFront #(.FifoDepth(FifoDepth)) uFront (
    .clk, .rstN,
    .AWADDR, .AWVALID, .AWREADY, .WDATA, .WVALID, .WREADY,
    .BRESP, .BVALID, .BREADY,
    .ARADDR, .ARVALID, .ARREADY, .RDATA, .RRESP, .RVALID, .RREADY,
    .ops(ops),
    .launchReady, .headValid, .headWord, .fifoCount, .inFlight, .pop
  );

  // ----------------------------------------------------------
  // Datapaths side by side
  // ----------------------------------------------------------
  pipeMultiplier #(.NumStages(NumStages)) uMul (
    .clk, .rstN, .ops(ops), .product
  );

  // Tag path picks its two fields off the launch bus
  assign slotIn.valid = ops.launch;
  assign slotIn.tag   = ops.tag;

  delayLine #(.NumStages(NumStages), .payloadT(tagSlotT)) uTagDelay (
    .clk, .rstN, .in(slotIn), .out(slotOut)
  );

  // Joins tag and product, owns the FIFO and credits
  resultMerge #(.NumStages(NumStages), .FifoDepth(FifoDepth)) uMerge (
    .clk, .rstN, .ops(ops), .slot(slotOut), .product, .pop,
    .launchReady, .headValid, .headWord, .fifoCount, .inFlight
  );

endmodule

`default_nettype wire

// ==== src/mulPkg.sv ====
`default_nettype none

package mulPkg;

  // ----------------------------------------------------------
  // Datapath widths
  // ----------------------------------------------------------
  localparam int OpWidth   = 12;
  localparam int TagWidth  = 8;
  localparam int ProdWidth = 2 * OpWidth;

  // AXI4-Lite port sizing
  localparam int AddrWidth = 4;
  localparam int DataWidth = 32;

  // ----------------------------------------------------------
  // Register map
  // ----------------------------------------------------------
  // Write only, carries tag and both operands
  localparam logic [AddrWidth-1:0] LaunchAddr = 4'h0;
  // Read only, pops the oldest result
  localparam logic [AddrWidth-1:0] PopAddr    = 4'h8;
  // Read only, FIFO count and in-flight count
  localparam logic [AddrWidth-1:0] StatusAddr = 4'hC;

  // AXI response codes
  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

  // Travels beside the multiplier
  typedef struct packed {
    logic                valid;
    logic [TagWidth-1:0] tag;
  } tagSlotT;

  // Tag in the top byte, product below it
  typedef struct packed {
    logic [TagWidth-1:0]  tag;
    logic [ProdWidth-1:0] product;
  } resultT;

endpackage

`default_nettype wire

// ==== src/opBus.sv ====
`default_nettype none

// One launch, valid for a single cycle
interface opBus;
  import mulPkg::*;

  // Pulse, credit is already checked by the front end
  logic                launch;
  // Operands, held until the next launch
  logic [OpWidth-1:0]  opA;
  logic [OpWidth-1:0]  opB;
  // Returned with the product
  logic [TagWidth-1:0] tag;

  // Front end side
  modport source (
    output launch,
    output opA,
    output opB,
    output tag
  );

  // Multiplier, tag path and merge side
  modport sink (
    input launch,
    input opA,
    input opB,
    input tag
  );

endinterface

`default_nettype wire

// ==== src/pipeMultiplier.sv ====
`default_nettype none

module pipeMultiplier #(
  parameter int NumStages = 3
) (
  input  logic                         clk,
  input  logic                         rstN,
  opBus.sink                           ops,
  output logic [mulPkg::ProdWidth-1:0] product
);
  import mulPkg::*;

  // Operands split in two halves
  localparam int HalfWidth = OpWidth / 2;
  // Partial products sit in stages 1 to NumStages-1
  localparam int PpDepth = (NumStages > 1) ? NumStages - 1 : 1;

  typedef logic [2*HalfWidth-1:0] ppT;

  // Shift and add of the four partial products
  function automatic logic [ProdWidth-1:0] sumParts(input ppT [3:0] pp);
    logic [ProdWidth-1:0] low;
    logic [ProdWidth-1:0] mid;
    logic [ProdWidth-1:0] high;
    low  = ProdWidth'(pp[0]);
    mid  = (ProdWidth'(pp[1]) + ProdWidth'(pp[2])) << HalfWidth;
    high = ProdWidth'(pp[3]) << (2 * HalfWidth);
    return low + mid + high;
  endfunction

  // ----------------------------------------------------------
  // Stage 1, partial products
  // ----------------------------------------------------------
  logic [HalfWidth-1:0] aLo, aHi, bLo, bHi;
  ppT [3:0]             ppNext;
  ppT [3:0]             ppPipe [PpDepth];

  assign aLo = ops.opA[HalfWidth-1:0];
  assign aHi = ops.opA[OpWidth-1:HalfWidth];
  assign bLo = ops.opB[HalfWidth-1:0];
  assign bHi = ops.opB[OpWidth-1:HalfWidth];

  assign ppNext[0] = aLo * bLo;
  assign ppNext[1] = aLo * bHi;
  assign ppNext[2] = aHi * bLo;
  assign ppNext[3] = aHi * bHi;

  // Loads only on a launch, saves toggling when idle
  always_ff @(posedge clk) begin
    if (ops.launch) begin
      ppPipe[0] <= ppNext;
    end
  end

  // Middle stages just carry the partials
  for (genvar s = 1; s < PpDepth; s++) begin : genPass
    always_ff @(posedge clk) begin
      ppPipe[s] <= ppPipe[s-1];
    end
  end

  // ----------------------------------------------------------
  // Last stage, final sum
  // ----------------------------------------------------------
  if (NumStages == 1) begin : genSumComb
    assign product = sumParts(ppPipe[0]);
  end else begin : genSumReg
    logic [ProdWidth-1:0] productQ;
    always_ff @(posedge clk) begin
      productQ <= sumParts(ppPipe[PpDepth-1]);
    end
    assign product = productQ;
  end

  // Product of a launch appears NumStages edges later
  productCorrect: assert property (
    @(posedge clk) disable iff (!rstN)
    ops.launch |-> ##NumStages
      product == $past(ProdWidth'(ops.opA) * ProdWidth'(ops.opB), NumStages)
  );

endmodule

`default_nettype wire

// ==== src/resultMerge.sv ====
`default_nettype none

module resultMerge #(
  parameter int NumStages = 3,
  parameter int FifoDepth = 4,
  localparam int CountWidth = $clog2(FifoDepth) + 1
) (
  input  logic                  clk,
  input  logic                  rstN,
  opBus.sink                    ops,
  input  mulPkg::tagSlotT       slot,
  input  logic [mulPkg::ProdWidth-1:0] product,
  input  logic                  pop,
  output logic                  launchReady,
  output logic                  headValid,
  output mulPkg::resultT        headWord,
  output logic [CountWidth-1:0] fifoCount,
  output logic [CountWidth-1:0] inFlight
);
  import mulPkg::*;

  localparam int PtrWidth  = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int MaskWidth = $clog2(NumStages + 1);
  localparam int SumWidth  = CountWidth + 1;

  // Pointer advance with explicit wrap
  function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] p);
    return (p == PtrWidth'(FifoDepth - 1)) ? '0 : p + 1'b1;
  endfunction

  // ----------------------------------------------------------
  // Post-reset mask
  // ----------------------------------------------------------
  // Delay taps hold garbage until NumStages edges have passed
  logic [MaskWidth-1:0] maskCnt;
  logic                 slotLive;
  logic                 push;

  assign slotLive = (maskCnt == MaskWidth'(NumStages));

  always_ff @(posedge clk) begin
    if (!rstN) begin
      maskCnt <= '0;
    end else if (!slotLive) begin
      maskCnt <= maskCnt + 1'b1;
    end
  end

  assign push = slot.valid && slotLive;

  // ----------------------------------------------------------
  // Result FIFO
  // ----------------------------------------------------------
  resultT                mem [FifoDepth];
  logic [PtrWidth-1:0]   wrPtr;
  logic [PtrWidth-1:0]   rdPtr;

  // Storage, no reset
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= '{tag: slot.tag, product: product};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      fifoCount <= '0;
      inFlight  <= '0;
    end else begin
      if (push) wrPtr <= nextPtr(wrPtr);
      if (pop) rdPtr <= nextPtr(rdPtr);
      fifoCount <= fifoCount + CountWidth'(push) - CountWidth'(pop);
      // Launches issued minus results landed
      inFlight  <= inFlight + CountWidth'(ops.launch) - CountWidth'(push);
    end
  end

  assign headValid = (fifoCount != '0);
  assign headWord  = mem[rdPtr];

  // Credit check, the launch on the bus right now counts too
  assign launchReady = (SumWidth'(fifoCount) + SumWidth'(inFlight)
                        + SumWidth'(ops.launch)) < SumWidth'(FifoDepth);

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  // Credit scheme keeps a slot free for every result in flight
  noPushFull: assert property (
    @(posedge clk) disable iff (!rstN)
    push |-> fifoCount != CountWidth'(FifoDepth)
  );

  // Front end pops only when it saw a head word
  noPopEmpty: assert property (
    @(posedge clk) disable iff (!rstN)
    pop |-> fifoCount != '0
  );

endmodule

`default_nettype wire

// ==== tests/mulAccelTb.sv ====
`default_nettype none

module mulAccelTb;
  import mulPkg::*;

  localparam int NumStages = 3;
  localparam int FifoDepth = 4;
  // Cycles allowed for any single handshake
  localparam int Timeout   = 100;
  // Cycles a launch must stay parked with no credit
  localparam int StallWait = 12;

  logic                 clk;
  logic                 rstN;
  logic [AddrWidth-1:0] AWADDR;
  logic                 AWVALID;
  logic                 AWREADY;
  logic [DataWidth-1:0] WDATA;
  logic                 WVALID;
  logic                 WREADY;
  logic [1:0]           BRESP;
  logic                 BVALID;
  logic                 BREADY;
  logic [AddrWidth-1:0] ARADDR;
  logic                 ARVALID;
  logic                 ARREADY;
  logic [DataWidth-1:0] RDATA;
  logic [1:0]           RRESP;
  logic                 RVALID;
  logic                 RREADY;

  // Test context shared with the checker
  logic [8*24-1:0]      testName;
  logic [1:0]           expResp;
  logic                 expectStall;
  logic                 testEnd;
  logic                 runDone;
  int                   passCount;
  int                   failCount;
  logic                 timedOut;
  int                   badKinds;

  mulAccelTop #(.NumStages(NumStages), .FifoDepth(FifoDepth)) dut (
    .clk, .rstN,
    .AWADDR, .AWVALID, .AWREADY, .WDATA, .WVALID, .WREADY,
    .BRESP, .BVALID, .BREADY,
    .ARADDR, .ARVALID, .ARREADY, .RDATA, .RRESP, .RVALID, .RREADY
  );

  resultChecker resultCheck (
    .clk, .rstN,
    .AWADDR, .AWVALID, .AWREADY, .WDATA, .WREADY,
    .BRESP, .BVALID, .BREADY,
    .ARADDR, .ARVALID, .ARREADY, .RDATA, .RRESP, .RVALID, .RREADY,
    .testName, .expResp, .expectStall, .testEnd, .runDone,
    .passCount, .failCount
  );

  // Period 40
  always #20 clk = ~clk;

  // ----------------------------------------------------------
  // Bus helpers entered and left on a falling edge
  // ----------------------------------------------------------
  function automatic logic [DataWidth-1:0] packLaunch(input int a, input int b, input int tag);
    // Tag on top, then B, then A
    return {8'(tag), 12'(b), 12'(a)};
  endfunction

  task automatic noteTimeout(input string what);
    $display("Timeout waiting for %0s in test %0s", what, testName);
    timedOut = 1'b1;
  endtask

  task automatic startWrite(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data);
    AWADDR  = addr;
    WDATA   = data;
    AWVALID = 1'b1;
    WVALID  = 1'b1;
  endtask

  // BVALID only rises on an accept
  task automatic waitWriteAccept();
    int n;
    n = 0;
    while (!BVALID && n < Timeout) begin
      @(negedge clk);
      n++;
    end
    AWVALID = 1'b0;
    WVALID  = 1'b0;
    if (!BVALID) begin
      noteTimeout("write accept");
    end
  endtask

  // Response is taken on the edge where BVALID drops
  task automatic finishWrite();
    int n;
    repeat ($urandom_range(0, 2)) @(negedge clk);
    BREADY = 1'b1;
    n = 0;
    while (BVALID && n < Timeout) begin
      @(negedge clk);
      n++;
    end
    BREADY = 1'b0;
    if (BVALID) begin
      noteTimeout("write response");
    end
  endtask

  task automatic axiWrite(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data);
    startWrite(addr, data);
    waitWriteAccept();
    if (!timedOut) begin
      finishWrite();
    end
  endtask

  task automatic axiRead(input logic [AddrWidth-1:0] addr);
    int n;
    ARADDR  = addr;
    ARVALID = 1'b1;
    n = 0;
    // RVALID rising marks the accept
    while (!RVALID && n < Timeout) begin
      @(negedge clk);
      n++;
    end
    ARVALID = 1'b0;
    if (!RVALID) begin
      noteTimeout("read accept");
      return;
    end
    repeat ($urandom_range(0, 2)) @(negedge clk);
    RREADY = 1'b1;
    n = 0;
    while (RVALID && n < Timeout) begin
      @(negedge clk);
      n++;
    end
    RREADY = 1'b0;
    if (RVALID) begin
      noteTimeout("read data");
    end
  endtask

  // Result lands NumStages+1 edges after the launch edge
  task automatic settle();
    repeat (NumStages + 2) @(negedge clk);
  endtask

  // ----------------------------------------------------------
  // Test kinds
  // ----------------------------------------------------------
  // Launch with no credit, free one slot, then it must go in
  task automatic stallLaunch(input int a, input int b, input int tag);
    startWrite(LaunchAddr, packLaunch(a, b, tag));
    expectStall = 1'b1;
    repeat (StallWait) @(negedge clk);
    expectStall = 1'b0;
    axiRead(PopAddr);
    if (!timedOut) begin
      waitWriteAccept();
    end
    if (!timedOut) begin
      finishWrite();
    end
  endtask

  task automatic runTest(input string kind, input int a, input int b, input int tag);
    repeat ($urandom_range(0, 3)) @(negedge clk);
    case (kind)
      "launch": axiWrite(LaunchAddr, packLaunch(a, b, tag));
      "burst": begin
        // Next launch goes in while earlier ones are still in the multiplier
        for (int i = 0; i < FifoDepth && !timedOut; i++) begin
          axiWrite(LaunchAddr, packLaunch(a + i, b + i, tag + i));
        end
      end
      "pop": begin
        settle();
        axiRead(PopAddr);
      end
      "status": begin
        settle();
        axiRead(StatusAddr);
      end
      "badaddr": begin
        // Operand A column holds the offset here
        axiWrite(AddrWidth'(a), packLaunch(a, b, tag));
        if (!timedOut) begin
          axiRead(AddrWidth'(a));
        end
      end
      "stall": stallLaunch(a, b, tag);
      default: begin
        $display("Test %0s has unknown kind %0s", testName, kind);
        badKinds++;
      end
    endcase
  endtask

  task automatic endTest();
    testEnd = 1'b1;
    @(negedge clk);
    testEnd = 1'b0;
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    string           line;
    string           kind;
    logic [8*24-1:0] nameBuf;
    logic [8*24-1:0] kindBuf;
    int              fd;
    int              code;
    int              a;
    int              b;
    int              tag;
    int              resp;
    int              numTests;
    clk         = 1'b0;
    rstN        = 1'b0;
    AWADDR      = '0;
    AWVALID     = 1'b0;
    WDATA       = '0;
    WVALID      = 1'b0;
    BREADY      = 1'b0;
    ARADDR      = '0;
    ARVALID     = 1'b0;
    RREADY      = 1'b0;
    testName    = '0;
    expResp     = '0;
    expectStall = 1'b0;
    testEnd     = 1'b0;
    runDone     = 1'b0;
    timedOut    = 1'b0;
    badKinds    = 0;
    numTests    = 0;
    void'($urandom(73511));
    fd = $fopen("tests/mulTests.txt", "r");

    repeat (8) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    repeat (NumStages + 1) @(negedge clk);

    if (fd == 0) begin
      $display("Could not open tests/mulTests.txt");
    end else begin
      while (!$feof(fd) && !timedOut) begin
        code = $fgets(line, fd);
        // Skip comment and blank lines
        if (code > 0 && line.getc(0) != "#") begin
          code = $sscanf(line, "%s %s %d %d %d %d", nameBuf, kindBuf, a, b, tag, resp);
          if (code == 6) begin
            testName = nameBuf;
            expResp  = 2'(resp);
            kind     = $sformatf("%0s", kindBuf);
            runTest(kind, a, b, tag);
            if (!timedOut) begin
              endTest();
              numTests++;
            end
          end
        end
      end
      $fclose(fd);
    end

    // Checker prints its counts on this pulse
    runDone = 1'b1;
    @(negedge clk);
    runDone = 1'b0;
    @(negedge clk);

    if (!timedOut && fd != 0 && badKinds == 0 && numTests > 0
        && failCount == 0 && passCount == numTests) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/mulTests.txt ====
# name kind a b tag resp, where a holds the offset for badaddr
# resp is the expected AXI code in decimal, 0 OKAY and 2 SLVERR
launchSmall   launch   3     5     17   0
popSmall      pop      0     0     0    0
launchMax     launch   4095  4095  255  0
popMax        pop      0     0     0    0
popEmpty      pop      0     0     0    2
burstFour     burst    100   200   32   0
statusFour    status   0     0     0    0
popBurstA     pop      0     0     0    0
popBurstB     pop      0     0     0    0
popBurstC     pop      0     0     0    0
popBurstD     pop      0     0     0    0
popDrained    pop      0     0     0    2
burstFill     burst    4000  3000  64   0
stallFull     stall    77    88    200  0
statusRefill  status   0     0     0    0
popFillB      pop      0     0     0    0
popFillC      pop      0     0     0    0
popFillD      pop      0     0     0    0
popStalled    pop      0     0     0    0
badWrite      badaddr  4     1     2    2
statusEmpty   status   0     0     0    0
launchZero    launch   0     4095  1    0
badOffset     badaddr  6     0     0    2
statusOne     status   0     0     0    0
popZero       pop      0     0     0    0

// ==== tests/resultChecker.sv ====
`default_nettype none

module resultChecker (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic [mulPkg::AddrWidth-1:0] AWADDR,
  input  logic                         AWVALID,
  input  logic                         AWREADY,
  input  logic [mulPkg::DataWidth-1:0] WDATA,
  input  logic                         WREADY,
  input  logic [1:0]                   BRESP,
  input  logic                         BVALID,
  input  logic                         BREADY,
  input  logic [mulPkg::AddrWidth-1:0] ARADDR,
  input  logic                         ARVALID,
  input  logic                         ARREADY,
  input  logic [mulPkg::DataWidth-1:0] RDATA,
  input  logic [1:0]                   RRESP,
  input  logic                         RVALID,
  input  logic                         RREADY,
  // Context of the running test
  input  logic [8*24-1:0]              testName,
  input  logic [1:0]                   expResp,
  input  logic                         expectStall,
  input  logic                         testEnd,
  input  logic                         runDone,
  output int                           passCount,
  output int                           failCount
);
  import mulPkg::*;

  // Expected result words in launch order
  logic [DataWidth-1:0] model [$];
  logic [DataWidth-1:0] expData;
  int                   testErrs;

  // Tag from bits 31:24, product of A (11:0) and B (23:12)
  function automatic logic [DataWidth-1:0] expectedWord(input logic [DataWidth-1:0] wdata);
    logic [23:0] a;
    logic [23:0] b;
    a = 24'(wdata[11:0]);
    b = 24'(wdata[23:12]);
    return {wdata[31:24], a * b};
  endfunction

  // Sampling on the rising edge sees values from before the DUT updates
  always @(posedge clk) begin
    if (!rstN) begin
      model.delete();
      expData   = '0;
      testErrs  = 0;
      passCount = 0;
      failCount = 0;
    end else begin
      // ----------------------------------------------------------
      // Write side
      // ----------------------------------------------------------
      // Address and data of a write go in on the same edge
      if (AWREADY !== WREADY) begin
        $display("Test %0s: write address and write data were not accepted together",
                 testName);
        testErrs++;
      end
      if (AWVALID && AWREADY) begin
        if (expectStall) begin
          $display("Test %0s: launch was accepted with no FIFO credit left", testName);
          testErrs++;
        end
        if (AWADDR == LaunchAddr) begin
          model.push_back(expectedWord(WDATA));
        end
      end
      if (BVALID && BREADY && BRESP !== expResp) begin
        $display("[FAIL] %0s BRESP expected %0d actual %0d", testName, expResp, BRESP);
        testErrs++;
      end

      // ----------------------------------------------------------
      // Read side
      // ----------------------------------------------------------
      // Expected data is fixed at address accept like the DUT read data
      if (ARVALID && ARREADY) begin
        case (ARADDR)
          PopAddr: begin
            if (model.size() > 0) begin
              expData = model.pop_front();
            end else begin
              expData = '0;
            end
          end
          // In-flight is zero once every launch has landed
          StatusAddr: expData = {24'b0, 4'b0, 4'(model.size())};
          default:    expData = '0;
        endcase
      end
      if (RVALID && RREADY) begin
        if (RRESP !== expResp) begin
          $display("[FAIL] %0s RRESP expected %0d actual %0d", testName, expResp, RRESP);
          testErrs++;
        end
        if (RDATA !== expData) begin
          $display("[FAIL] %0s RDATA expected 0x%08h actual 0x%08h",
                   testName, expData, RDATA);
          testErrs++;
        end
      end

      // One line per finished test
      if (testEnd) begin
        if (testErrs == 0) begin
          $display("[PASS] %0s", testName);
          passCount++;
        end else begin
          $display("Test %0s finished with %0d errors", testName, testErrs);
          failCount++;
        end
        testErrs = 0;
      end
      if (runDone) begin
        $display("Tests passed %0d, failed %0d", passCount, failCount);
      end
    end
  end

endmodule

`default_nettype wire
